//--- hdl/arm_types_pkg.sv
`default_nettype none

package arm_types_pkg;

    // Basic data types of the execution unit
    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    // Condition flags packed as NZCV with N in the top bit
    typedef logic [3:0]  flags_t;

    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // Wishbone word address map
    localparam int WB_ADDR_W = 5;

    localparam logic [WB_ADDR_W-1:0] WB_INSTR_ADDR = 5'd0;  // Instruction write port
    localparam logic [WB_ADDR_W-1:0] WB_FLAGS_ADDR = 5'd16; // NZCV read-back

    // Registers r0 to r15 are read at word addresses 0 to 15

endpackage

`default_nettype wire

//--- hdl/dp_ops_pkg.sv
`default_nettype none

package dp_ops_pkg;

    // Data-processing opcodes in instruction encoding order
    typedef enum logic [3:0] {
        ALU_OP_AND = 4'h0,
        ALU_OP_EOR = 4'h1,
        ALU_OP_SUB = 4'h2,
        ALU_OP_RSB = 4'h3,
        ALU_OP_ADD = 4'h4,
        ALU_OP_ADC = 4'h5,
        ALU_OP_SBC = 4'h6,
        ALU_OP_RSC = 4'h7,
        ALU_OP_TST = 4'h8,
        ALU_OP_TEQ = 4'h9,
        ALU_OP_CMP = 4'ha,
        ALU_OP_CMN = 4'hb,
        ALU_OP_ORR = 4'hc,
        ALU_OP_MOV = 4'hd,
        ALU_OP_BIC = 4'he,
        ALU_OP_MVN = 4'hf
    } alu_op_t;

    typedef enum logic [1:0] {
        SHIFT_LSL,
        SHIFT_LSR,
        SHIFT_ASR,
        SHIFT_ROR
    } shift_t;

    // NV is never executed
    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC,
        COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT,
        COND_GT, COND_LE, COND_AL, COND_NV
    } cond_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT_REG,
        ST_EXEC,
        ST_ACK
    } core_state_t;

    // Instruction field positions
    localparam int COND_LSB       = 28;
    localparam int IMM_BIT        = 25;
    localparam int OPCODE_LSB     = 21;
    localparam int S_BIT          = 20;
    localparam int RN_LSB         = 16;
    localparam int RD_LSB         = 12;
    localparam int RS_LSB         = 8;
    localparam int ROT_LSB        = 8;  // Rotate field of the immediate form
    localparam int SHIFT_IMM_LSB  = 7;
    localparam int SHIFT_TYPE_LSB = 5;
    localparam int SHIFT_REG_BIT  = 4;
    localparam int RM_LSB         = 0;
    localparam int IMM8_LSB       = 0;

endpackage

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire                           clk,
    input  wire                           reset,
    input  wire arm_types_pkg::reg_idx_t  rd_idx_a,
    input  wire arm_types_pkg::reg_idx_t  rd_idx_b,
    output arm_types_pkg::word_t          rd_data_a,
    output arm_types_pkg::word_t          rd_data_b,
    input  wire                           wr_en,
    input  wire arm_types_pkg::reg_idx_t  wr_idx,
    input  wire arm_types_pkg::word_t     wr_data
);
    import arm_types_pkg::*;

    word_t regs [16];

    // Reads are combinational and see a write only after its edge
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/barrel_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module barrel_shifter (
    input  wire arm_types_pkg::word_t  operand,
    input  wire dp_ops_pkg::shift_t    shift_type,
    input  wire [7:0]                  amount,
    input  wire                        imm_form,
    input  wire                        carry_in,
    output arm_types_pkg::word_t       shift_out,
    output logic                       shift_carry
);
    import dp_ops_pkg::*;

    logic [7:0]  eff_amount;
    logic [4:0]  rot;
    logic [32:0] wide;

    // An immediate LSR #0 or ASR #0 encodes a shift by 32
    always_comb begin
        if (imm_form && amount == 8'd0 &&
            (shift_type == SHIFT_LSR || shift_type == SHIFT_ASR)) begin
            eff_amount = 8'd32;
        end else begin
            eff_amount = amount;
        end
    end

    assign rot = eff_amount[4:0]; // ROR works modulo 32

    always_comb begin
        wide        = '0;
        shift_out   = operand;
        shift_carry = carry_in;
        if (eff_amount != 8'd0) begin
            case (shift_type)
                SHIFT_LSL: begin
                    if (eff_amount < 8'd32) begin
                        wide        = {1'b0, operand} << eff_amount;
                        shift_out   = wide[31:0];
                        shift_carry = wide[32];  // Last bit shifted out at the top
                    end else begin
                        shift_out   = '0;
                        shift_carry = (eff_amount == 8'd32) ? operand[0] : 1'b0;
                    end
                end
                SHIFT_LSR: begin
                    if (eff_amount < 8'd32) begin
                        wide        = {operand, 1'b0} >> eff_amount;
                        shift_out   = wide[32:1];
                        shift_carry = wide[0];
                    end else begin
                        shift_out   = '0;
                        shift_carry = (eff_amount == 8'd32) ? operand[31] : 1'b0;
                    end
                end
                SHIFT_ASR: begin
                    if (eff_amount < 8'd32) begin
                        wide        = $signed({operand, 1'b0}) >>> eff_amount;
                        shift_out   = wide[32:1];
                        shift_carry = wide[0];
                    end else begin
                        shift_out   = {32{operand[31]}};
                        shift_carry = operand[31];
                    end
                end
                default: begin
                    shift_out   = (operand >> rot) | (operand << (6'd32 - {1'b0, rot}));
                    shift_carry = shift_out[31]; // Also right for multiples of 32
                end
            endcase
        end
    end

    // A rotate only moves bits around, so it keeps the number of ones
    always_comb begin
        if (shift_type == SHIFT_ROR) begin
            assert final ($countones(shift_out) == $countones(operand))
                else $error("rotate changed the number of set bits");
        end
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire                         clk,
    input  wire                         reset,
    input  wire dp_ops_pkg::alu_op_t    alu_op,
    input  wire arm_types_pkg::word_t   op_a,
    input  wire arm_types_pkg::word_t   shift_out,
    input  wire                         shift_carry,
    input  wire                         carry_in,
    input  wire                         latch_op_b,
    input  wire                         use_op_b_latch,
    output arm_types_pkg::word_t        result,
    output arm_types_pkg::flags_t       flags_out
);
    import arm_types_pkg::*;
    import dp_ops_pkg::*;

    word_t       op_b_latch;
    word_t       op_b;
    word_t       add_x;
    word_t       add_y;
    logic        add_cin;
    logic [32:0] sum;
    logic        add_v;
    logic        is_arith;

    // Holds the shifted Rm across the extra cycle of a shift by register
    always_ff @(posedge clk) begin
        if (reset) begin
            op_b_latch <= '0;
        end else if (latch_op_b) begin
            op_b_latch <= shift_out;
        end
    end

    assign op_b = use_op_b_latch ? op_b_latch : shift_out;

    assign is_arith = alu_op inside {ALU_OP_SUB, ALU_OP_RSB, ALU_OP_ADD, ALU_OP_ADC,
                                     ALU_OP_SBC, ALU_OP_RSC, ALU_OP_CMP, ALU_OP_CMN};

    // Subtraction is done as x + ~y + cin so that carry out is NOT borrow
    always_comb begin
        add_x   = op_a;
        add_y   = op_b;
        add_cin = 1'b0;
        case (alu_op)
            ALU_OP_ADC: add_cin = carry_in;
            ALU_OP_SUB, ALU_OP_CMP: begin
                add_y   = ~op_b;
                add_cin = 1'b1;
            end
            ALU_OP_SBC: begin
                add_y   = ~op_b;
                add_cin = carry_in;
            end
            ALU_OP_RSB: begin
                add_x   = op_b;
                add_y   = ~op_a;
                add_cin = 1'b1;
            end
            ALU_OP_RSC: begin
                add_x   = op_b;
                add_y   = ~op_a;
                add_cin = carry_in;
            end
            default: add_cin = 1'b0; // ADD and CMN
        endcase
    end

    assign sum   = {1'b0, add_x} + {1'b0, add_y} + {32'h0, add_cin};
    assign add_v = (add_x[31] == add_y[31]) && (sum[31] != add_x[31]);

    always_comb begin
        case (alu_op)
            ALU_OP_AND, ALU_OP_TST: result = op_a & op_b;
            ALU_OP_EOR, ALU_OP_TEQ: result = op_a ^ op_b;
            ALU_OP_ORR:             result = op_a | op_b;
            ALU_OP_BIC:             result = op_a & ~op_b;
            ALU_OP_MOV:             result = op_b;
            ALU_OP_MVN:             result = ~op_b;
            default:                result = sum[31:0];
        endcase
    end

    // Logical ops report V as zero and the core keeps its own V for them
    always_comb begin
        flags_out         = '0;
        flags_out[FLAG_N] = result[31];
        flags_out[FLAG_Z] = (result == '0);
        flags_out[FLAG_C] = is_arith ? sum[32] : shift_carry;
        flags_out[FLAG_V] = is_arith ? add_v : 1'b0;
    end

    // The core must never load the latch in the same cycle it consumes it
    assert property (@(posedge clk) disable iff (reset) !(latch_op_b && use_op_b_latch))
        else $error("operand B latch loaded and used in the same cycle");

endmodule

`default_nettype wire

//--- hdl/dp_core.sv
`timescale 1ns/1ns
`default_nettype none

module dp_core (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 cyc,
    input  wire                                 stb,
    input  wire                                 we,
    input  wire [arm_types_pkg::WB_ADDR_W-1:0]  adr,
    input  wire arm_types_pkg::word_t           dat_w,
    output arm_types_pkg::word_t                dat_r,
    output logic                                ack
);
    import arm_types_pkg::*;
    import dp_ops_pkg::*;

    core_state_t state;
    core_state_t state_next;
    word_t       instr_q;
    flags_t      flags_q;
    flags_t      flags_d;
    logic        shift_c_q;

    reg_idx_t    rn;
    reg_idx_t    rd;
    reg_idx_t    rs;
    reg_idx_t    rm;
    reg_idx_t    rd_idx_a;
    word_t       rd_data_a;
    word_t       rd_data_b;
    logic        wr_en;

    word_t       shift_operand;
    shift_t      shift_type;
    logic [7:0]  shift_amount;
    logic        shift_imm_form;
    logic [4:0]  shift_imm;
    word_t       shift_out;
    logic        shift_carry;

    alu_op_t     alu_op;
    word_t       alu_result;
    flags_t      alu_flags;
    logic        latch_op_b;
    logic        use_op_b_latch;

    logic        wb_start;
    logic        op_imm;
    logic        op_reg_shift;
    logic        exec_ok;
    logic        logical_op;

    function automatic logic cond_pass(input cond_t cond, input flags_t f);
        logic n;
        logic z;
        logic c;
        logic v;
        n = f[FLAG_N];
        z = f[FLAG_Z];
        c = f[FLAG_C];
        v = f[FLAG_V];
        case (cond)
            COND_EQ: return z;
            COND_NE: return !z;
            COND_CS: return c;
            COND_CC: return !c;
            COND_MI: return n;
            COND_PL: return !n;
            COND_VS: return v;
            COND_VC: return !v;
            COND_HI: return c && !z;
            COND_LS: return !c || z;
            COND_GE: return n == v;
            COND_LT: return n != v;
            COND_GT: return !z && (n == v);
            COND_LE: return z || (n != v);
            COND_AL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    assign wb_start     = cyc && stb;
    assign op_imm       = instr_q[IMM_BIT];
    assign op_reg_shift = !instr_q[IMM_BIT] && instr_q[SHIFT_REG_BIT];
    assign alu_op       = alu_op_t'(instr_q[OPCODE_LSB +: 4]);
    assign rn           = instr_q[RN_LSB +: 4];
    assign rd           = instr_q[RD_LSB +: 4];
    assign rs           = instr_q[RS_LSB +: 4];
    assign rm           = instr_q[RM_LSB +: 4];
    assign shift_imm    = instr_q[SHIFT_IMM_LSB +: 5];

    assign exec_ok    = (state == ST_EXEC) && cond_pass(cond_t'(instr_q[COND_LSB +: 4]), flags_q);
    assign logical_op = alu_op inside {ALU_OP_AND, ALU_OP_EOR, ALU_OP_TST, ALU_OP_TEQ,
                                       ALU_OP_ORR, ALU_OP_MOV, ALU_OP_BIC, ALU_OP_MVN};
    assign wr_en      = exec_ok &&
                        !(alu_op inside {ALU_OP_TST, ALU_OP_TEQ, ALU_OP_CMP, ALU_OP_CMN});

    assign latch_op_b     = (state == ST_SHIFT_REG);
    assign use_op_b_latch = (state == ST_EXEC) && op_reg_shift;

    // Port A serves host reads in idle, Rs for the shift amount, then Rn
    always_comb begin
        case (state)
            ST_IDLE:      rd_idx_a = adr[3:0];
            ST_SHIFT_REG: rd_idx_a = rs;
            default:      rd_idx_a = rn;
        endcase
    end

    always_comb begin
        shift_type     = shift_t'(instr_q[SHIFT_TYPE_LSB +: 2]);
        shift_operand  = rd_data_b;
        shift_imm_form = 1'b1;
        if (op_imm) begin
            shift_operand = {24'h0, instr_q[IMM8_LSB +: 8]};
            shift_type    = SHIFT_ROR;
            shift_amount  = {3'b000, instr_q[ROT_LSB +: 4], 1'b0};
        end else if (op_reg_shift) begin
            shift_amount   = rd_data_a[7:0];
            shift_imm_form = 1'b0;
        end else if (shift_type == SHIFT_ROR && shift_imm == 5'd0) begin
            shift_amount = 8'd32; // Without RRX a ROR #0 acts as ROR #32
        end else begin
            shift_amount = {3'b000, shift_imm};
        end
    end

    // Logical ops keep the old V and the ALU supplies the rest
    always_comb begin
        flags_d = alu_flags;
        if (logical_op) begin
            flags_d[FLAG_V] = flags_q[FLAG_V];
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (wb_start && we && adr == WB_INSTR_ADDR) begin
                    state_next = (!dat_w[IMM_BIT] && dat_w[SHIFT_REG_BIT]) ? ST_SHIFT_REG : ST_EXEC;
                end else if (wb_start) begin
                    state_next = ST_ACK;
                end
            end
            ST_SHIFT_REG: state_next = ST_EXEC;
            ST_EXEC:      state_next = ST_ACK;
            default:      state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            flags_q <= '0;
        end else begin
            state <= state_next;
            if (exec_ok && instr_q[S_BIT]) begin
                flags_q <= flags_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && wb_start) begin
            if (we && adr == WB_INSTR_ADDR) begin
                instr_q <= dat_w;
            end
            if (!adr[4]) begin
                dat_r <= rd_data_a;
            end else if (adr == WB_FLAGS_ADDR) begin
                dat_r <= {28'h0, flags_q};
            end else begin
                dat_r <= '0;
            end
        end
        if (latch_op_b) begin
            shift_c_q <= shift_carry; // Shifter carry must outlive the Rs read
        end
    end

    assign ack = (state == ST_ACK);

    reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rm),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_idx    (rd),
        .wr_data   (alu_result)
    );

    barrel_shifter u_barrel_shifter (
        .operand     (shift_operand),
        .shift_type  (shift_type),
        .amount      (shift_amount),
        .imm_form    (shift_imm_form),
        .carry_in    (flags_q[FLAG_C]),
        .shift_out   (shift_out),
        .shift_carry (shift_carry)
    );

    alu u_alu (
        .clk            (clk),
        .reset          (reset),
        .alu_op         (alu_op),
        .op_a           (rd_data_a),
        .shift_out      (shift_out),
        .shift_carry    (use_op_b_latch ? shift_c_q : shift_carry),
        .carry_in       (flags_q[FLAG_C]),
        .latch_op_b     (latch_op_b),
        .use_op_b_latch (use_op_b_latch),
        .result         (alu_result),
        .flags_out      (alu_flags)
    );

    // The master keeps the cycle open until the acknowledge and then drops the strobe
    assert property (@(posedge clk) disable iff (reset) ack |-> cyc && stb)
        else $error("ack raised outside an active Wishbone cycle");
    assert property (@(posedge clk) disable iff (reset) ack |=> !stb)
        else $error("strobe still high in the cycle after ack");

endmodule

`default_nettype wire

//--- test/dp_model.svh
`ifndef DP_MODEL_SVH
`define DP_MODEL_SVH

// Reference copy of the register file and the NZCV flags
word_t  m_regs [16];
flags_t m_flags;

function automatic void reset_state();
    for (int i = 0; i < 16; i++) begin
        m_regs[i] = '0;
    end
    m_flags = '0;
endfunction

function automatic logic cond_holds(cond_t cond, flags_t f);
    case (cond)
        COND_EQ: return f[FLAG_Z];
        COND_NE: return !f[FLAG_Z];
        COND_CS: return f[FLAG_C];
        COND_CC: return !f[FLAG_C];
        COND_MI: return f[FLAG_N];
        COND_PL: return !f[FLAG_N];
        COND_VS: return f[FLAG_V];
        COND_VC: return !f[FLAG_V];
        COND_HI: return f[FLAG_C] && !f[FLAG_Z];
        COND_LS: return !f[FLAG_C] || f[FLAG_Z];
        COND_GE: return f[FLAG_N] == f[FLAG_V];
        COND_LT: return f[FLAG_N] != f[FLAG_V];
        COND_GT: return !f[FLAG_Z] && (f[FLAG_N] == f[FLAG_V]);
        COND_LE: return f[FLAG_Z] || (f[FLAG_N] != f[FLAG_V]);
        COND_AL: return 1'b1;
        default: return 1'b0; // NV never runs
    endcase
endfunction

// Shifts by the ARM rules and returns {carry, value}
function automatic logic [32:0] shift_value(word_t val, shift_t kind, int amt, logic cin);
    int    k;
    word_t asr;
    k = amt % 32;
    if (amt == 0) begin
        return {cin, val};
    end
    case (kind)
        SHIFT_LSL: begin
            if (amt < 32) begin
                return {val[32 - amt], val << amt};
            end
            return {amt == 32 && val[0], 32'h0};
        end
        SHIFT_LSR: begin
            if (amt < 32) begin
                return {val[amt - 1], val >> amt};
            end
            return {amt == 32 && val[31], 32'h0};
        end
        SHIFT_ASR: begin
            if (amt < 32) begin
                asr = $signed(val) >>> amt;
                return {val[amt - 1], asr};
            end
            return {val[31], {32{val[31]}}};
        end
        default: begin
            if (k == 0) begin
                return {val[31], val}; // Whole turns leave the value and carry bit 31
            end
            return {val[k - 1], (val >> k) | (val << (32 - k))};
        end
    endcase
endfunction

function automatic logic [32:0] operand2(word_t instr);
    int     amt;
    shift_t kind;
    logic   cin;
    cin = m_flags[FLAG_C];
    if (instr[IMM_BIT]) begin
        // The 8-bit immediate rotates right by twice the rotate field
        return shift_value({24'h0, instr[7:0]}, SHIFT_ROR, 2 * instr[11:8], cin);
    end
    kind = shift_t'(instr[SHIFT_TYPE_LSB +: 2]);
    if (instr[SHIFT_REG_BIT]) begin
        amt = m_regs[instr[RS_LSB +: 4]][7:0];
    end else begin
        amt = instr[11:7];
        if (amt == 0 && kind != SHIFT_LSL) begin
            amt = 32; // An encoded zero means 32 for all but LSL
        end
    end
    return shift_value(m_regs[instr[RM_LSB +: 4]], kind, amt, cin);
endfunction

// Result is {V, C, sum}
function automatic logic [33:0] add_flags(word_t x, word_t y, logic cin);
    logic [32:0] s;
    s = {1'b0, x} + {1'b0, y} + {32'h0, cin};
    return {(x[31] == y[31]) && (s[31] != x[31]), s};
endfunction

// x - y - NOT cin, with C set when no borrow occurs
function automatic logic [33:0] sub_flags(word_t x, word_t y, logic cin);
    word_t d;
    logic  c;
    d = x - y - {31'h0, !cin};
    c = {1'b0, x} >= ({1'b0, y} + {32'h0, !cin});
    return {(x[31] != y[31]) && (d[31] != x[31]), c, d};
endfunction

function automatic void apply_instr(word_t instr);
    alu_op_t     op;
    word_t       a;
    word_t       b;
    logic        cin;
    logic [32:0] op2;
    logic [33:0] ar;
    op = alu_op_t'(instr[OPCODE_LSB +: 4]);
    if (!cond_holds(cond_t'(instr[COND_LSB +: 4]), m_flags)) begin
        return;
    end
    op2 = operand2(instr);
    a   = m_regs[instr[RN_LSB +: 4]];
    b   = op2[31:0];
    cin = m_flags[FLAG_C];
    ar  = {m_flags[FLAG_V], op2[32], 32'h0}; // Logical ops keep V and take the shifter carry
    case (op)
        ALU_OP_AND, ALU_OP_TST: ar[31:0] = a & b;
        ALU_OP_EOR, ALU_OP_TEQ: ar[31:0] = a ^ b;
        ALU_OP_ORR:             ar[31:0] = a | b;
        ALU_OP_MOV:             ar[31:0] = b;
        ALU_OP_BIC:             ar[31:0] = a & ~b;
        ALU_OP_MVN:             ar[31:0] = ~b;
        ALU_OP_SUB, ALU_OP_CMP: ar = sub_flags(a, b, 1'b1);
        ALU_OP_RSB:             ar = sub_flags(b, a, 1'b1);
        ALU_OP_ADD, ALU_OP_CMN: ar = add_flags(a, b, 1'b0);
        ALU_OP_ADC:             ar = add_flags(a, b, cin);
        ALU_OP_SBC:             ar = sub_flags(a, b, cin);
        default:                ar = sub_flags(b, a, cin); // RSC
    endcase
    if (instr[S_BIT]) begin
        m_flags = {ar[31], ar[31:0] == 32'h0, ar[32], ar[33]};
    end
    if (!(op inside {ALU_OP_TST, ALU_OP_TEQ, ALU_OP_CMP, ALU_OP_CMN})) begin
        m_regs[instr[RD_LSB +: 4]] = ar[31:0];
    end
endfunction

`endif

//--- test/dp_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dp_tb;
    import arm_types_pkg::*;
    import dp_ops_pkg::*;

    localparam logic [31:0] SEED      = 32'h00b8_123c;
    localparam int          N_ARITH   = 150;
    localparam int          N_LOGIC   = 150;
    localparam int          N_COMPARE = 100;
    localparam int          N_COND    = 200;
    localparam int          N_RANDOM  = N_ARITH + N_LOGIC + N_COMPARE + N_COND;

    // A write takes up to 5 cycles with its idle gap and a read takes 3
    localparam int N_WRITES   = N_RANDOM + 16 + 64 + 6;
    localparam int N_READS    = 2 * N_RANDOM + 2 * 16 + 4 * 17;
    localparam int MAX_CYCLES = 5 * N_WRITES + 3 * N_READS + 100;

    // Register shift amounts kept in r10 to r15
    localparam logic [47:0] SHIFT_AMTS = {8'd255, 8'd33, 8'd32, 8'd31, 8'd1, 8'd0};

    logic                 clk;
    logic                 reset;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADDR_W-1:0] adr;
    word_t                dat_w;
    word_t                dat_r;
    logic                 ack;
    logic [31:0]          rng;
    int                   errors;
    int                   cycles = 0;

    `include "dp_model.svh"

    dp_core uut (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // One classic cycle, with the strobe held over the edge that ends ack
    task automatic wb_transfer(input logic write, input logic [WB_ADDR_W-1:0] addr,
                               input word_t data, output word_t rdata);
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = data;
        do begin
            @(negedge clk);
        end while (!ack);
        rdata = dat_r;
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] addr, input word_t data);
        word_t unused;
        wb_transfer(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] addr, output word_t data);
        wb_transfer(1'b0, addr, 32'h0, data);
    endtask

    task automatic run_instr(input word_t instr);
        wb_write(WB_INSTR_ADDR, instr);
        apply_instr(instr);
    endtask

    task automatic check_reg(input int idx);
        word_t got;
        wb_read(idx[WB_ADDR_W-1:0], got);
        if (got !== m_regs[idx]) begin
            errors++;
            $display("MISMATCH dat_r r%0d: got %h expected %h", idx, got, m_regs[idx]);
        end
    endtask

    task automatic check_flags();
        word_t got;
        wb_read(WB_FLAGS_ADDR, got);
        if (got !== {28'h0, m_flags}) begin
            errors++;
            $display("MISMATCH dat_r flags: got %h expected %h", got, {28'h0, m_flags});
        end
    endtask

    task automatic check_all();
        for (int i = 0; i < 16; i++) begin
            check_reg(i);
        end
        check_flags();
    endtask

    function automatic word_t make_instr(cond_t cond, alu_op_t op, logic s, reg_idx_t rn,
                                         reg_idx_t rd, logic [12:0] op2);
        return {cond, 2'b00, op2[12], op, s, rn, rd, op2[11:0]};
    endfunction

    // Form 0 immediate, 1 shift by immediate, 2 shift by r10 to r15, 3 plain register
    function automatic logic [12:0] random_op2(int form);
        logic [31:0] r;
        logic [4:0]  amt;
        r = next_rand();
        case (r[31:30])
            2'd0:    amt = 5'd0;
            2'd1:    amt = 5'd1;
            2'd2:    amt = 5'd31;
            default: amt = r[11:7];
        endcase
        case (form)
            0:       return {1'b1, r[11:0]};
            1:       return {1'b0, amt, r[6:5], 1'b0, r[3:0]};
            2:       return {1'b0, 4'(10 + r[11:8] % 6), 1'b0, r[6:5], 1'b1, r[3:0]};
            default: return {9'h0, r[3:0]};
        endcase
    endfunction

    function automatic alu_op_t logic_op(logic [31:0] r);
        logic [3:0] idx;
        idx = 4'(r[31:16] % 6);
        return alu_op_t'(idx < 4'd2 ? idx : idx + 4'd10); // AND, EOR, then ORR to MVN
    endfunction

    // Builds a full word from a MOV and three ORRs of rotated bytes
    task automatic load_word(input reg_idx_t idx, input word_t value);
        run_instr(make_instr(COND_AL, ALU_OP_MOV, 1'b0, idx, idx, {1'b1, 4'd0, value[7:0]}));
        run_instr(make_instr(COND_AL, ALU_OP_ORR, 1'b0, idx, idx, {1'b1, 4'd12, value[15:8]}));
        run_instr(make_instr(COND_AL, ALU_OP_ORR, 1'b0, idx, idx, {1'b1, 4'd8, value[23:16]}));
        run_instr(make_instr(COND_AL, ALU_OP_ORR, 1'b0, idx, idx, {1'b1, 4'd4, value[31:24]}));
    endtask

    initial begin
        logic [31:0] r;
        reg_idx_t    rd;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        reset  = 1'b1;
        rng    = SEED;
        errors = 0;
        reset_state();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_all();

        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            run_instr(make_instr(COND_AL, ALU_OP_MOV, 1'b1, r[19:16], reg_idx_t'(i),
                                 {1'b1, r[11:0]}));
            check_reg(i);
            check_flags();
        end

        // Edge operands stay in r0 to r3 while arithmetic writes r4 to r15
        load_word(4'd0, 32'h7fff_ffff);
        load_word(4'd1, 32'h8000_0000);
        load_word(4'd2, 32'hffff_ffff);
        load_word(4'd3, 32'h0000_0000);
        for (int i = 4; i < 16; i++) begin
            load_word(reg_idx_t'(i), next_rand());
        end
        check_all();
        for (int i = 0; i < N_ARITH; i++) begin
            r  = next_rand();
            rd = reg_idx_t'(4 + r[7:0] % 12);
            run_instr(make_instr(COND_AL, alu_op_t'(4'(2 + r[31:16] % 6)), 1'b1, r[15:12], rd,
                                 {9'h0, r[11:8]}));
            check_reg(rd);
            check_flags();
        end

        for (int k = 0; k < 6; k++) begin
            run_instr(make_instr(COND_AL, ALU_OP_MOV, 1'b0, 4'd0, reg_idx_t'(10 + k),
                                 {1'b1, 4'd0, SHIFT_AMTS[8 * k +: 8]}));
        end
        for (int i = 0; i < N_LOGIC; i++) begin
            r  = next_rand();
            rd = reg_idx_t'(r[7:0] % 10);
            run_instr(make_instr(COND_AL, logic_op(r), 1'b1, r[15:12], rd, random_op2(1 + r[8])));
            check_reg(rd);
            check_flags();
        end

        for (int i = 0; i < N_COMPARE; i++) begin
            r = next_rand();
            run_instr(make_instr(COND_AL, alu_op_t'(4'd8 + r[1:0]), 1'b1, r[15:12], r[11:8],
                                 random_op2(r[3:2])));
            check_reg(r[11:8]);
            check_flags();
        end
        check_all(); // Compares and tests must not have touched any register

        for (int i = 0; i < N_COND; i++) begin
            r = next_rand();
            run_instr(make_instr(cond_t'(r[31:28]), alu_op_t'(r[24:21]), r[20], r[19:16],
                                 r[15:12], random_op2(r[3:2])));
            check_reg(r[15:12]);
            check_flags();
        end
        check_all();

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+test
hdl/arm_types_pkg.sv
hdl/dp_ops_pkg.sv
hdl/reg_file.sv
hdl/barrel_shifter.sv
hdl/alu.sv
hdl/dp_core.sv
test/dp_tb.sv
